// File: logic/apb_ctrl_regs.sv
`timescale 1ns/1ns

module apb_ctrl_regs (
    input  logic                              mipi0_dphy_rx_clk,
    input  logic                              reset,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [mipi_rx_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [mipi_rx_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [mipi_rx_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                              pready_o,
    output logic [mipi_rx_pkg::LED_W-1:0]      led_o,
    output logic                              sensor_rstn_o,
    output logic [mipi_rx_pkg::SETTLE_W-1:0]   settle_cycles_o
);
    import mipi_rx_pkg::*;

    logic                access;               // apb access phase
    logic                wr_en;
    logic [LED_W-1:0]    led_reg;
    logic [SPARE_W-1:0]  spare_reg;
    ctrl_reg_u           ctrl_reg;
    ctrl_reg_u           ctrl_wdata;           // bus word seen as fields
    ctrl_reg_u           ctrl_masked;          // only the defined fields

    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;

    // ------------------------------
    // write path
    // ------------------------------
    always_comb begin
        ctrl_wdata.raw                   = pwdata_i;
        ctrl_masked.raw                  = '0;
        ctrl_masked.fields.sensor_rstn   = ctrl_wdata.fields.sensor_rstn;
        ctrl_masked.fields.settle_cycles = ctrl_wdata.fields.settle_cycles;
    end

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            led_reg                       <= '0;
            spare_reg                     <= '0;
            ctrl_reg.raw                  <= '0;
            ctrl_reg.fields.settle_cycles <= SETTLE_RESET;  // sensor held in reset
        end else if (wr_en) begin
            case (paddr_i)
                ADDR_LED: begin
                    led_reg <= pwdata_i[LED_W-1:0];
                end
                ADDR_CTRL: begin
                    ctrl_reg <= ctrl_masked;
                end
                ADDR_SPARE: begin
                    spare_reg <= pwdata_i[SPARE_W-1:0];
                end
                default: begin
                    // unmapped address drops the write
                end
            endcase
        end
    end

    // ------------------------------
    // read path
    // ------------------------------
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            ADDR_LED:   prdata_o = APB_DATA_W'(led_reg);
            ADDR_CTRL:  prdata_o = ctrl_reg.raw;
            ADDR_SPARE: prdata_o = APB_DATA_W'(spare_reg);
            default:    prdata_o = '0;
        endcase
    end

    assign pready_o        = access;                      // no wait states
    assign led_o           = led_reg;
    assign sensor_rstn_o   = ctrl_reg.fields.sensor_rstn;
    assign settle_cycles_o = ctrl_reg.fields.settle_cycles;

endmodule

// File: logic/hs_byte_gate.sv
`timescale 1ns/1ns

module hs_byte_gate (
    input  logic                              mipi0_dphy_rx_clk,
    input  logic                              reset,
    input  logic                              odt_armed_i,
    input  logic                              lp_stopped_i,
    input  logic [mipi_rx_pkg::LP_W-1:0]       lp_lane0_i,
    input  logic [mipi_rx_pkg::LP_W-1:0]       lp_lane1_i,
    input  logic [mipi_rx_pkg::SETTLE_W-1:0]   settle_cycles_i,
    input  logic [mipi_rx_pkg::LANE_COUNT-1:0] hsrxd_vld_i,
    input  logic [mipi_rx_pkg::HS_WORD_W-1:0]  d0ln_hsrxd_i,
    input  logic [mipi_rx_pkg::HS_WORD_W-1:0]  d1ln_hsrxd_i,
    output logic [mipi_rx_pkg::LANE_COUNT-1:0] hsrx_odten_o,
    output logic                              byte_ready_o,
    output logic [mipi_rx_pkg::BYTE_W-1:0]     byte_d0_o,
    output logic [mipi_rx_pkg::BYTE_W-1:0]     byte_d1_o
);
    import mipi_rx_pkg::*;

    logic [SETTLE_W-1:0] settle_cnt;
    logic                hs_window;               // counter was nonzero
    logic                byte_ready;
    logic [BYTE_W-1:0]   byte_d0;
    logic [BYTE_W-1:0]   byte_d1;

    // ------------------------------
    // termination per lane
    // ------------------------------
    assign hsrx_odten_o = {lp_lane1_i == LP00, lp_lane0_i == LP00}
                        & {LANE_COUNT{odt_armed_i}};

    // ------------------------------
    // settle counter and window
    // ------------------------------
    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            settle_cnt <= '0;
            hs_window  <= 1'b0;
            byte_ready <= 1'b0;
        end else begin
            if (lp_stopped_i) begin
                settle_cnt <= '0;                 // stop state ends the burst
            end else if (|hsrx_odten_o) begin
                settle_cnt <= settle_cycles_i;
            end else if (settle_cnt != '0) begin
                settle_cnt <= settle_cnt - SETTLE_W'(1);
            end

            hs_window  <= (settle_cnt != '0);
            byte_ready <= hs_window && hsrxd_vld_i[0];
        end
    end

    // payload captured every cycle
    always_ff @(posedge mipi0_dphy_rx_clk) begin
        byte_d0 <= d0ln_hsrxd_i[BYTE_W-1:0];
        byte_d1 <= d1ln_hsrxd_i[BYTE_W-1:0];
    end

    assign byte_ready_o = byte_ready;
    assign byte_d0_o    = byte_d0;
    assign byte_d1_o    = byte_d1;

endmodule

// File: logic/lp_sequence_detector.sv
`timescale 1ns/1ns

module lp_sequence_detector (
    input  logic                        mipi0_dphy_rx_clk,
    input  logic                        reset,
    input  logic [mipi_rx_pkg::LP_W-1:0] lp_lane0_i,
    output logic                        odt_armed_o,
    output logic                        lp_stopped_o,
    output logic                        drst_n_o
);
    import mipi_rx_pkg::*;

    logic [LP_W-1:0] lp_cur;                      // newest sampled state
    logic [LP_W-1:0] lp_prev;                     // one sample older
    logic            arm;                         // lp11 -> lp01 entry seen
    logic            odt_msk;
    logic            drst_n;

    // ------------------------------
    // transition decode
    // ------------------------------
    logic from3to1;
    logic from1to0;
    logic from1to2;
    logic from1to3;
    logic fromxto3;
    logic from1_leave;                            // leaves lp01, not to lp00

    assign from3to1    = (lp_prev == LP11) && (lp_cur == LP01);
    assign from1to0    = (lp_prev == LP01) && (lp_cur == LP00);
    assign from1to2    = (lp_prev == LP01) && (lp_cur == LP10);
    assign from1to3    = (lp_prev == LP01) && (lp_cur == LP11);
    assign fromxto3    = (lp_prev != LP11) && (lp_cur == LP11);
    assign from1_leave = (lp_prev == LP01) && (lp_cur != LP01) && (lp_cur != LP00);

    // ------------------------------
    // history and flags
    // ------------------------------
    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            lp_cur  <= LP11;                      // lines idle in stop state
            lp_prev <= LP11;
            arm     <= 1'b0;
            odt_msk <= 1'b0;
            drst_n  <= 1'b1;
        end else begin
            lp_cur  <= lp_lane0_i;
            lp_prev <= lp_cur;

            if (!arm) begin
                arm <= from3to1;
            end else if (from1_leave) begin
                arm <= 1'b0;                      // lp00 keeps it set
            end

            if (!odt_msk) begin
                odt_msk <= from3to1;
            end else if (from1to2 || from1to3 || fromxto3) begin
                odt_msk <= 1'b0;
            end

            drst_n <= !(arm && from1to0);         // single low cycle
        end
    end

    assign odt_armed_o  = odt_msk;
    assign lp_stopped_o = (lp_cur == LP11);       // from the history register
    assign drst_n_o     = drst_n;

endmodule

// File: logic/mipi_rx_frontend.sv
`timescale 1ns/1ns

module mipi_rx_frontend (
    input  logic                              mipi0_dphy_rx_clk,
    input  logic                              reset,

    input  logic                              apb_psel_i,
    input  logic                              apb_penable_i,
    input  logic                              apb_pwrite_i,
    input  logic [mipi_rx_pkg::APB_ADDR_W-1:0] apb_paddr_i,
    input  logic [mipi_rx_pkg::APB_DATA_W-1:0] apb_pwdata_i,
    output logic [mipi_rx_pkg::APB_DATA_W-1:0] apb_prdata_o,
    output logic                              apb_pready_o,

    input  logic [mipi_rx_pkg::LP_W-1:0]       lp_lane0_i,
    input  logic [mipi_rx_pkg::LP_W-1:0]       lp_lane1_i,
    input  logic [mipi_rx_pkg::LANE_COUNT-1:0] hsrxd_vld_i,
    input  logic [mipi_rx_pkg::HS_WORD_W-1:0]  d0ln_hsrxd_i,
    input  logic [mipi_rx_pkg::HS_WORD_W-1:0]  d1ln_hsrxd_i,

    output logic [mipi_rx_pkg::LANE_COUNT-1:0] hsrx_odten_o,
    output logic                              drst_n_o,
    output logic                              byte_ready_o,
    output logic [mipi_rx_pkg::BYTE_W-1:0]     byte_d0_o,
    output logic [mipi_rx_pkg::BYTE_W-1:0]     byte_d1_o,
    output logic                              sensor_rstn_o,
    output logic [mipi_rx_pkg::LED_W-1:0]      led_o
);
    import mipi_rx_pkg::*;

    logic                odt_armed;
    logic                lp_stopped;
    logic [SETTLE_W-1:0] settle_cycles;

    // ------------------------------
    // lane 0 lp sequencing
    // ------------------------------
    lp_sequence_detector u_lp_seq (
        .mipi0_dphy_rx_clk (mipi0_dphy_rx_clk),
        .reset             (reset),
        .lp_lane0_i        (lp_lane0_i),
        .odt_armed_o       (odt_armed),
        .lp_stopped_o      (lp_stopped),
        .drst_n_o          (drst_n_o)             // to phy data reset
    );

    // ------------------------------
    // control registers
    // ------------------------------
    apb_ctrl_regs u_regs (
        .mipi0_dphy_rx_clk (mipi0_dphy_rx_clk),
        .reset             (reset),
        .psel_i            (apb_psel_i),
        .penable_i         (apb_penable_i),
        .pwrite_i          (apb_pwrite_i),
        .paddr_i           (apb_paddr_i),
        .pwdata_i          (apb_pwdata_i),
        .prdata_o          (apb_prdata_o),
        .pready_o          (apb_pready_o),
        .led_o             (led_o),
        .sensor_rstn_o     (sensor_rstn_o),       // sensor reset pin
        .settle_cycles_o   (settle_cycles)
    );

    // ------------------------------
    // hs gating and byte stage
    // ------------------------------
    hs_byte_gate u_gate (
        .mipi0_dphy_rx_clk (mipi0_dphy_rx_clk),
        .reset             (reset),
        .odt_armed_i       (odt_armed),
        .lp_stopped_i      (lp_stopped),
        .lp_lane0_i        (lp_lane0_i),
        .lp_lane1_i        (lp_lane1_i),
        .settle_cycles_i   (settle_cycles),
        .hsrxd_vld_i       (hsrxd_vld_i),
        .d0ln_hsrxd_i      (d0ln_hsrxd_i),
        .d1ln_hsrxd_i      (d1ln_hsrxd_i),
        .hsrx_odten_o      (hsrx_odten_o),
        .byte_ready_o      (byte_ready_o),
        .byte_d0_o         (byte_d0_o),
        .byte_d1_o         (byte_d1_o)
    );

endmodule

// File: logic/mipi_rx_pkg.sv
package mipi_rx_pkg;

    // ------------------------------
    // lane and word geometry
    // ------------------------------
    localparam int LANE_COUNT = 2;
    localparam int LP_W       = 2;                // {p, n} pair of one lane
    localparam int HS_WORD_W  = 16;
    localparam int BYTE_W     = 8;
    localparam int SETTLE_W   = 6;

    // lp line states with p in bit 1 and n in bit 0
    localparam logic [LP_W-1:0] LP00 = 2'b00;
    localparam logic [LP_W-1:0] LP01 = 2'b01;
    localparam logic [LP_W-1:0] LP10 = 2'b10;
    localparam logic [LP_W-1:0] LP11 = 2'b11;     // stop state

    localparam logic [SETTLE_W-1:0] SETTLE_RESET = 6'd10;

    // ------------------------------
    // register block
    // ------------------------------
    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;
    localparam int LED_W      = 4;
    localparam int SPARE_W    = 8;

    localparam logic [APB_ADDR_W-1:0] ADDR_LED   = 4'h0;
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL  = 4'h4;
    localparam logic [APB_ADDR_W-1:0] ADDR_SPARE = 4'h8;

    typedef struct packed {
        logic [17:0]         rsvd_hi;             // reads zero
        logic [SETTLE_W-1:0] settle_cycles;       // bits 13:8
        logic [6:0]          rsvd_lo;             // reads zero
        logic                sensor_rstn;         // bit 0
    } ctrl_fields_t;

    // control word as raw bus data or as fields for the logic
    typedef union packed {
        logic [APB_DATA_W-1:0] raw;
        ctrl_fields_t          fields;
    } ctrl_reg_u;

endpackage

// File: sources.f
logic/mipi_rx_pkg.sv
logic/lp_sequence_detector.sv
logic/apb_ctrl_regs.sv
logic/hs_byte_gate.sv
logic/mipi_rx_frontend.sv
tests/mipi_rx_frontend_checker.sv
tests/tb_mipi_rx_frontend.sv

// File: tests/mipi_rx_frontend_checker.sv
`timescale 1ns/1ns

module mipi_rx_frontend_checker (
    input  logic                              mipi0_dphy_rx_clk,
    input  logic                              reset,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pready_i,
    input  logic                              drst_n_i,
    input  logic [mipi_rx_pkg::LANE_COUNT-1:0] odten_i,
    input  logic                              byte_ready_i,
    input  logic [mipi_rx_pkg::SETTLE_W-1:0]   settle_cycles_i
);
    import mipi_rx_pkg::*;

    int         assert_fails = 0;
    logic [7:0] idle_cnt;                         // cycles since last odt enable

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            idle_cnt <= '0;
        end else if (|odten_i) begin
            idle_cnt <= '0;
        end else if (idle_cnt != 8'hFF) begin
            idle_cnt <= idle_cnt + 8'd1;
        end
    end

    // ------------------------------
    a_pready_access: assert property (@(posedge mipi0_dphy_rx_clk) disable iff (reset)
        pready_i |-> (psel_i && penable_i))
    else begin
        $error("pready high outside the APB access phase");
        assert_fails++;
    end

    a_drst_single: assert property (@(posedge mipi0_dphy_rx_clk) disable iff (reset)
        !drst_n_i |=> drst_n_i)
    else begin
        $error("data reset held low for more than one cycle");
        assert_fails++;
    end

    // counter drains and then window and ready add a cycle each
    a_ready_idle: assert property (@(posedge mipi0_dphy_rx_clk) disable iff (reset)
        (idle_cnt > ({2'b00, settle_cycles_i} + 8'd1)) |-> !byte_ready_i)
    else begin
        $error("byte ready long after the ODT enables dropped");
        assert_fails++;
    end

endmodule

// File: tests/mipi_rx_tests.txt
# W addr data | R addr expected | O exp_sensor_rstn exp_led | T test_name
# L lp0 lp1 vld d0 d1 exp_drst_n exp_odten exp_ready exp_b0 exp_b1 (outputs one cycle later)
T reset_and_registers
O 0 0
L 3 3 0 0000 0000 1 0 0 00 00
R 4 00000A00
R 0 00000000
R 8 00000000
W 0 00000005
R 0 00000005
W 8 000000A5
R 8 000000A5
W 8 00001234
R 8 00000034
W 4 FFFFFFFF
R 4 00003F01
W C 0000DEAD
R C 00000000
R 2 00000000
W 4 00000A00
R 4 00000A00
T sensor_and_led
W 4 00000A01
O 1 5
W 0 0000000A
O 1 A
W 4 00000A00
O 0 A
W 0 00000000
O 0 0
T data_reset_pulse
L 3 3 0 0000 0000 1 0 0 00 00
L 1 3 0 0000 0000 1 0 0 00 00
L 0 3 0 0000 0000 1 1 0 00 00
L 0 3 0 0000 0000 0 1 0 00 00
L 0 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
# stop state straight to lp00, no pulse
L 3 3 0 0000 0000 1 0 0 00 00
L 0 3 0 0000 0000 1 0 0 00 00
L 0 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
T odt_enables
L 3 3 0 0000 0000 1 0 0 00 00
L 1 3 0 0000 0000 1 0 0 00 00
L 0 3 0 0000 0000 1 3 0 00 00
L 0 0 0 0000 0000 0 1 0 00 00
L 0 1 0 0000 0000 1 3 0 00 00
L 0 0 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
T byte_capture
L 3 3 0 0000 0000 1 0 0 00 00
L 1 1 0 0000 0000 1 0 0 00 00
L 0 0 0 0000 0000 1 3 0 00 00
L 0 0 0 0000 0000 0 3 0 00 00
L 0 0 0 0000 0000 1 3 0 00 00
L 0 0 3 EF69 9FC4 1 3 1 69 C4
L 0 0 1 87FA BDC7 1 3 1 FA C7
L 0 0 2 3668 6B69 1 0 0 68 69
L 3 3 0 5986 51CB 1 0 0 86 CB
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 3 A511 AA87 1 0 0 11 87
L 3 3 0 0000 0000 1 0 0 00 00
T settle_count
W 4 00000301
R 4 00000301
L 3 3 0 0000 0000 1 0 0 00 00
L 1 1 0 0000 0000 1 0 0 00 00
L 0 0 0 0000 0000 1 3 0 00 00
L 0 0 0 0000 0000 0 3 0 00 00
L 0 0 3 EF69 9FC4 1 3 0 69 C4
L 0 0 3 87FA BDC7 1 0 1 FA C7
L 1 1 3 3668 6B69 1 0 1 68 69
L 1 1 3 5986 51CB 1 0 1 86 CB
L 1 1 3 A511 AA87 1 0 1 11 87
L 1 1 3 EF69 9FC4 1 0 1 69 C4
L 1 1 3 87FA BDC7 1 0 0 FA C7
L 3 3 0 0000 0000 1 0 0 00 00
L 3 3 0 0000 0000 1 0 0 00 00

// File: tests/tb_mipi_rx_frontend.sv
`timescale 1ns/1ns

module tb_mipi_rx_frontend;
    import mipi_rx_pkg::*;

    localparam int APB_TIMEOUT = 16;
    localparam int MAX_LINES   = 500;

    logic                  mipi0_dphy_rx_clk = 1'b0;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic [LP_W-1:0]       lp_lane0;
    logic [LP_W-1:0]       lp_lane1;
    logic [LANE_COUNT-1:0] hsrxd_vld;
    logic [HS_WORD_W-1:0]  d0ln_hsrxd;
    logic [HS_WORD_W-1:0]  d1ln_hsrxd;
    logic [LANE_COUNT-1:0] hsrx_odten;
    logic                  drst_n;
    logic                  byte_ready;
    logic [BYTE_W-1:0]     byte_d0;
    logic [BYTE_W-1:0]     byte_d1;
    logic                  sensor_rstn;
    logic [LED_W-1:0]      led;

    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          test_checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          timed_out = 1'b0;
    string       test_name = "";
    bit          pend_valid = 1'b0;                // lane line waiting for its check
    logic [31:0] pend_exp [5];

    always #50 mipi0_dphy_rx_clk = ~mipi0_dphy_rx_clk;

    mipi_rx_frontend dut (
        .mipi0_dphy_rx_clk (mipi0_dphy_rx_clk),
        .reset             (reset),
        .apb_psel_i        (psel),
        .apb_penable_i     (penable),
        .apb_pwrite_i      (pwrite),
        .apb_paddr_i       (paddr),
        .apb_pwdata_i      (pwdata),
        .apb_prdata_o      (prdata),
        .apb_pready_o      (pready),
        .lp_lane0_i        (lp_lane0),
        .lp_lane1_i        (lp_lane1),
        .hsrxd_vld_i       (hsrxd_vld),
        .d0ln_hsrxd_i      (d0ln_hsrxd),
        .d1ln_hsrxd_i      (d1ln_hsrxd),
        .hsrx_odten_o      (hsrx_odten),
        .drst_n_o          (drst_n),
        .byte_ready_o      (byte_ready),
        .byte_d0_o         (byte_d0),
        .byte_d1_o         (byte_d1),
        .sensor_rstn_o     (sensor_rstn),
        .led_o             (led)
    );

    bind mipi_rx_frontend mipi_rx_frontend_checker u_checker (
        .mipi0_dphy_rx_clk (mipi0_dphy_rx_clk),
        .reset             (reset),
        .psel_i            (apb_psel_i),
        .penable_i         (apb_penable_i),
        .pready_i          (apb_pready_o),
        .drst_n_i          (drst_n_o),
        .odten_i           (hsrx_odten_o),
        .byte_ready_i      (byte_ready_o),
        .settle_cycles_i   (settle_cycles)
    );

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_pending();
        if (pend_valid) begin
            compare("drst_n", 32'(drst_n), pend_exp[0]);
            compare("odt enables", 32'(hsrx_odten), pend_exp[1]);
            compare("byte ready", 32'(byte_ready), pend_exp[2]);
            compare("lane 0 byte", 32'(byte_d0), pend_exp[3]);
            compare("lane 1 byte", 32'(byte_d1), pend_exp[4]);
            pend_valid = 1'b0;
        end
    endtask

    // last lane line still needs the edge that samples it
    task automatic flush_lane();
        if (pend_valid) begin
            @(posedge mipi0_dphy_rx_clk);
            @(negedge mipi0_dphy_rx_clk);
            check_pending();
        end
    endtask

    task automatic apb_xfer(input bit wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output bit ok);
        int waited;
        waited = 0;
        @(posedge mipi0_dphy_rx_clk);
        psel    <= 1'b1;                            // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr[APB_ADDR_W-1:0];
        pwdata  <= wdata;
        @(posedge mipi0_dphy_rx_clk);
        penable <= 1'b1;
        @(negedge mipi0_dphy_rx_clk);
        while (!pready && waited < APB_TIMEOUT) begin
            @(negedge mipi0_dphy_rx_clk);
            waited++;
        end
        ok    = pready;
        rdata = prdata;
        @(posedge mipi0_dphy_rx_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("test %s: ok, %0d checks", test_name, test_checks);
            end else begin
                tests_failed++;
                $display("test %s: %0d of %0d checks wrong", test_name, test_errors, test_checks);
            end
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        bit          ok;
        string       line;
        string       tag;
        string       name;
        logic [31:0] f [10];
        logic [31:0] rd;
        line_no    = 0;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lp_lane0   = LP11;
        lp_lane1   = LP11;
        hsrxd_vld  = '0;
        d0ln_hsrxd = '0;
        d1ln_hsrxd = '0;
        repeat (8) @(posedge mipi0_dphy_rx_clk);
        reset <= 1'b0;

        fd = $fopen("tests/mipi_rx_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/mipi_rx_tests.txt");
            errors++;
        end
        while (fd != 0 && !timed_out && line_no < MAX_LINES) begin
            if ($fgets(line, fd) == 0) break;
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%s", tag);
            if (tag == "L") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", tag,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                @(posedge mipi0_dphy_rx_clk);
                lp_lane0   <= f[0][LP_W-1:0];
                lp_lane1   <= f[1][LP_W-1:0];
                hsrxd_vld  <= f[2][LANE_COUNT-1:0];
                d0ln_hsrxd <= f[3][HS_WORD_W-1:0];
                d1ln_hsrxd <= f[4][HS_WORD_W-1:0];
                @(negedge mipi0_dphy_rx_clk);
                check_pending();
                for (int i = 0; i < 5; i++) begin
                    pend_exp[i] = f[i + 5];
                end
                pend_valid = (n == 11);
                if (n != 11) begin
                    $display("line %0d of the stimulus file has missing fields", line_no);
                    errors++;
                end
            end else if (tag == "W" || tag == "R") begin
                n = $sscanf(line, "%s %h %h", tag, f[0], f[1]);
                flush_lane();
                apb_xfer(tag == "W", f[0], f[1], rd, ok);
                if (!ok) begin
                    $display("APB access to %h got no pready within %0d cycles", f[0],
                             APB_TIMEOUT);
                    timed_out = 1'b1;
                end else if (tag == "R") begin
                    compare($sformatf("read of %h", f[0][APB_ADDR_W-1:0]), rd, f[1]);
                end
            end else if (tag == "O") begin
                n = $sscanf(line, "%s %h %h", tag, f[0], f[1]);
                flush_lane();
                @(negedge mipi0_dphy_rx_clk);
                compare("sensor_rstn", 32'(sensor_rstn), f[0]);
                compare("led", 32'(led), f[1]);
            end else if (tag == "T") begin
                n = $sscanf(line, "%s %s", tag, name);
                flush_lane();
                close_test();
                test_name = name;
            end else begin
                $display("line %0d of the stimulus file is not understood", line_no);
                errors++;
            end
        end
        if (!timed_out) begin
            flush_lane();
        end
        close_test();
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, dut.u_checker.assert_fails);
        if (errors == 0 && !timed_out && tests_run > 0 && dut.u_checker.assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
